//--- src/simt_pkg.sv
// ------------------------------
// SIMT warp shared definitions
// Warp sizes, register map and reset PC
// ------------------------------
package simt_pkg;

    // Warp shape
    localparam int NUM_THREADS = 4;
    localparam int PC_W        = 32;

    // Post-dominator stack geometry
    localparam int STACK_DEPTH = 4;
    localparam int STACK_AW    = $clog2(STACK_DEPTH);
    localparam int ENTRY_W     = NUM_THREADS + PC_W;

    typedef logic [NUM_THREADS-1:0] tmask_t;
    typedef logic [PC_W-1:0]        pc_t;

    // Wishbone data and word address widths
    localparam int BUS_W = 32;
    localparam int ADR_W = 2;

    // Word addresses of the register map
    localparam logic [ADR_W-1:0] ADR_CMD   = 2'd0;
    localparam logic [ADR_W-1:0] ADR_ELSE  = 2'd1;
    localparam logic [ADR_W-1:0] ADR_IPDOM = 2'd2;

    // A command word with this bit set is a join, otherwise a split
    localparam int CMD_JOIN_BIT = 31;

    // Status word layout with the thread mask in the low bits
    localparam int STATUS_FULL  = 6;
    localparam int STATUS_EMPTY = 5;
    localparam int STATUS_ERR   = 4;

    localparam pc_t RESET_PC = 32'h0000_1000;

endpackage

//--- src/dp_ram.sv
// ------------------------------
// Dual-port RAM with registered write
// and asynchronous read
// ------------------------------
module dp_ram #(
    parameter int width = 72,
    parameter int depth = 4
) (
    input  logic                     clk,
    input  logic                     write,
    input  logic [$clog2(depth)-1:0] waddr,
    input  logic [width-1:0]         wdata,
    input  logic [$clog2(depth)-1:0] raddr,
    output logic [width-1:0]         rdata
);

    logic [width-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (write) begin
            mem[waddr] <= wdata;
        end
    end

    // Read path is combinational so the stack can serve a pop in the same cycle
    assign rdata = mem[raddr];

endmodule

//--- src/ipdom_stack.sv
// ------------------------------
// Immediate post-dominator stack
// Two slots per entry with the else slot first
// ------------------------------
module ipdom_stack import simt_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic [ENTRY_W-1:0] q0,
    input  logic [ENTRY_W-1:0] q1,
    input  logic               push,
    input  logic               pop,
    output logic [ENTRY_W-1:0] d,
    output logic               d_set,
    output logic               empty,
    output logic               full
);

    logic [STACK_AW-1:0]    rd_ptr;
    logic [STACK_AW-1:0]    wr_ptr;
    logic [STACK_DEPTH-1:0] slot_used;
    logic [ENTRY_W-1:0]     d0;
    logic [ENTRY_W-1:0]     d1;
    logic                   top_used;

    // Set once the else slot of the top entry has been handed out
    assign top_used = slot_used[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr    <= '0;
            wr_ptr    <= '0;
            slot_used <= '0;
            empty     <= 1'b1;
            full      <= 1'b0;
        end else if (push) begin
            rd_ptr            <= wr_ptr;
            wr_ptr            <= wr_ptr + STACK_AW'(1);
            slot_used[wr_ptr] <= 1'b0;
            empty             <= 1'b0;
            full              <= (wr_ptr == STACK_AW'(STACK_DEPTH - 1));
        end else if (pop) begin
            slot_used[rd_ptr] <= 1'b1;
            // Pointers only retreat when the reconvergence slot is consumed
            rd_ptr <= rd_ptr - STACK_AW'(top_used);
            wr_ptr <= wr_ptr - STACK_AW'(top_used);
            empty  <= (rd_ptr == '0) && top_used;
            // The entry stays occupied until its second pop
            if (top_used) begin
                full <= 1'b0;
            end
        end
    end

    dp_ram #(
        .width (2 * ENTRY_W),
        .depth (STACK_DEPTH)
    ) store (
        .clk   (clk),
        .write (push),
        .waddr (wr_ptr),
        .wdata ({q1, q0}),
        .raddr (rd_ptr),
        .rdata ({d1, d0})
    );

    assign d     = top_used ? d0 : d1;
    assign d_set = !top_used;

    // The control must never overrun or underrun the stack
    a_no_push_full: assert property (@(posedge clk) disable iff (reset) !(push && full));
    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) !(pop && empty));
    a_push_xor_pop: assert property (@(posedge clk) disable iff (reset) !(push && pop));

endmodule

//--- src/divergence_ctl.sv
// ------------------------------
// Warp divergence control
// Thread mask, PC and split/join decisions
// ------------------------------
module divergence_ctl import simt_pkg::*; (
    input  logic               clk,
    input  logic               reset,

    // Commands from the bus slave
    input  logic               split_req,
    input  tmask_t             pred,
    input  logic               join_req,
    input  pc_t                else_pc,
    input  pc_t                ipdom_pc,

    // Warp state
    output tmask_t             tmask,
    output pc_t                pc,
    output logic               err,

    // Stack side
    output logic               push,
    output logic               pop,
    output logic [ENTRY_W-1:0] q0,
    output logic [ENTRY_W-1:0] q1,
    input  logic [ENTRY_W-1:0] d,
    input  logic               d_set,
    input  logic               empty,
    input  logic               full
);

    tmask_t taken;
    tmask_t not_taken;
    logic   divergent;
    logic   split_overflow;
    logic   join_underflow;

    assign taken     = tmask & pred;
    assign not_taken = tmask & ~pred;

    // Only a predicate that splits the active threads needs a stack entry
    assign divergent = (|taken) && (|not_taken);

    assign push = split_req && divergent && !full;
    assign pop  = join_req && !empty;

    assign split_overflow = split_req && divergent && full;
    assign join_underflow = join_req && empty;

    // Else slot resumes the not-taken threads, the other slot reconverges
    assign q1 = {not_taken, else_pc};
    assign q0 = {tmask, ipdom_pc};

    always_ff @(posedge clk) begin
        if (reset) begin
            tmask <= '1;
            pc    <= RESET_PC;
            err   <= 1'b0;
        end else begin
            if (push) begin
                tmask <= taken;
            end else if (pop) begin
                // Slot choice is made inside the stack
                {tmask, pc} <= d;
            end

            if (split_overflow || join_underflow) begin
                err <= 1'b1;
            end
        end
    end

    // The bus slave decodes one command per write
    a_one_cmd: assert property (@(posedge clk) disable iff (reset)
        !(split_req && join_req));

    // Handing out an else slot leaves its entry on the stack for the reconvergence pop
    a_else_keeps_entry: assert property (@(posedge clk) disable iff (reset)
        (pop && d_set) |=> !empty);

endmodule

//--- src/wb_simt_regs.sv
// ------------------------------
// Wishbone classic register slave
// Pending PCs, command pulses, status
// ------------------------------
module wb_simt_regs import simt_pkg::*; (
    input  logic             clk,
    input  logic             reset,

    // Wishbone classic slave
    input  logic             cyc,
    input  logic             stb,
    input  logic             we,
    input  logic [ADR_W-1:0] adr,
    input  logic [BUS_W-1:0] dat_w,
    input  logic [3:0]       sel,
    output logic [BUS_W-1:0] dat_r,
    output logic             ack,

    // Commands and pending PCs
    output logic             split_req,
    output logic             join_req,
    output tmask_t           pred,
    output pc_t              else_pc,
    output pc_t              ipdom_pc,

    // Warp state for read back
    input  tmask_t           tmask,
    input  pc_t              pc,
    input  logic             err,
    input  logic             empty,
    input  logic             full
);

    logic             req;
    logic             wr_cmd;
    logic [BUS_W-1:0] status;

    // A new request is taken only while ack is low
    assign req    = cyc && stb && !ack;
    assign wr_cmd = req && we && (adr == ADR_CMD);

    always_comb begin
        status                    = '0;
        status[NUM_THREADS-1:0]   = tmask;
        status[STATUS_ERR]        = err;
        status[STATUS_EMPTY]      = empty;
        status[STATUS_FULL]       = full;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack       <= 1'b0;
            split_req <= 1'b0;
            join_req  <= 1'b0;
            else_pc   <= '0;
            ipdom_pc  <= '0;
        end else begin
            ack       <= req;
            // Pulses line up with the ack cycle
            split_req <= wr_cmd && !dat_w[CMD_JOIN_BIT];
            join_req  <= wr_cmd && dat_w[CMD_JOIN_BIT];
            if (req && we && (adr == ADR_ELSE)) begin
                else_pc <= dat_w[PC_W-1:0];
            end
            if (req && we && (adr == ADR_IPDOM)) begin
                ipdom_pc <= dat_w[PC_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            pred <= dat_w[NUM_THREADS-1:0];
            case (adr)
                ADR_CMD:   dat_r <= status;
                ADR_ELSE:  dat_r <= BUS_W'(pc);
                ADR_IPDOM: dat_r <= BUS_W'(ipdom_pc);
                default:   dat_r <= '0;
            endcase
        end
    end

    a_ack_single: assert property (@(posedge clk) disable iff (reset) ack |=> !ack);

    // Master holds the whole request until it sees ack
    a_req_held: assert property (@(posedge clk) disable iff (reset)
        req |=> (cyc && stb && $stable({we, adr, dat_w, sel})));

endmodule

//--- src/simt_top.sv
// ------------------------------
// SIMT warp divergence unit
// Bus slave, control and IPDOM stack
// ------------------------------
module simt_top import simt_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             cyc,
    input  logic             stb,
    input  logic             we,
    input  logic [ADR_W-1:0] adr,
    input  logic [BUS_W-1:0] dat_w,
    input  logic [3:0]       sel,
    output logic [BUS_W-1:0] dat_r,
    output logic             ack
);

    logic               split_req;
    logic               join_req;
    tmask_t             pred;
    pc_t                else_pc;
    pc_t                ipdom_pc;
    tmask_t             tmask;
    pc_t                pc;
    logic               err;
    logic               push;
    logic               pop;
    logic [ENTRY_W-1:0] q0;
    logic [ENTRY_W-1:0] q1;
    logic [ENTRY_W-1:0] d;
    logic               d_set;
    logic               empty;
    logic               full;

    wb_simt_regs regs (
        .clk       (clk),
        .reset     (reset),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_w     (dat_w),
        .sel       (sel),
        .dat_r     (dat_r),
        .ack       (ack),
        .split_req (split_req),
        .join_req  (join_req),
        .pred      (pred),
        .else_pc   (else_pc),
        .ipdom_pc  (ipdom_pc),
        .tmask     (tmask),
        .pc        (pc),
        .err       (err),
        .empty     (empty),
        .full      (full)
    );

    divergence_ctl ctl (
        .clk       (clk),
        .reset     (reset),
        .split_req (split_req),
        .pred      (pred),
        .join_req  (join_req),
        .else_pc   (else_pc),
        .ipdom_pc  (ipdom_pc),
        .tmask     (tmask),
        .pc        (pc),
        .err       (err),
        .push      (push),
        .pop       (pop),
        .q0        (q0),
        .q1        (q1),
        .d         (d),
        .d_set     (d_set),
        .empty     (empty),
        .full      (full)
    );

    ipdom_stack stack (
        .clk   (clk),
        .reset (reset),
        .q0    (q0),
        .q1    (q1),
        .push  (push),
        .pop   (pop),
        .d     (d),
        .d_set (d_set),
        .empty (empty),
        .full  (full)
    );

endmodule

//--- bench/clk_gen.sv
// ------------------------------
// Testbench clock source
// Free-running clock with a period of 40
// ------------------------------
module clk_gen (
    output logic clk
);

    localparam int HALF_PERIOD = 20;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

//--- bench/tb_simt.sv
// ------------------------------
// SIMT divergence unit testbench
// Table-driven Wishbone test with a warp model
// ------------------------------
module tb_simt import simt_pkg::*; ();

    localparam int OP_WRITE  = 0;
    localparam int OP_STATUS = 1;
    localparam int OP_PC     = 2;
    localparam int ACK_WAIT  = 8;

    logic             clk;
    logic             reset;
    logic             cyc;
    logic             stb;
    logic             we;
    logic [ADR_W-1:0] adr;
    logic [BUS_W-1:0] dat_w;
    logic [3:0]       sel;
    logic [BUS_W-1:0] dat_r;
    logic             ack;

    // Stimulus table with one entry per bus cycle
    int               row_op[$];
    logic [ADR_W-1:0] row_adr[$];
    logic [BUS_W-1:0] row_dat[$];
    logic [BUS_W-1:0] row_exp[$];
    string            row_note[$];

    // Warp model and its list of pushed pairs with the top entry last
    tmask_t m_mask;
    pc_t    m_pc;
    pc_t    m_else;
    pc_t    m_ipdom;
    logic   m_err;
    tmask_t stk_emask[$];
    pc_t    stk_epc[$];
    tmask_t stk_rmask[$];
    pc_t    stk_rpc[$];
    logic   stk_used[$];

    int seed        = 32'h25a;
    int cycles      = 0;
    int cycle_limit = 0;
    int tests       = 0;
    int failures    = 0;

    clk_gen clock (.clk(clk));

    simt_top DUT (
        .clk   (clk),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .sel   (sel),
        .dat_r (dat_r),
        .ack   (ack)
    );

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [BUS_W-1:0] model_status();
        logic [BUS_W-1:0] s;
        s                    = '0;
        s[NUM_THREADS-1:0]   = m_mask;
        s[STATUS_ERR]        = m_err;
        s[STATUS_EMPTY]      = (stk_used.size() == 0);
        s[STATUS_FULL]       = (stk_used.size() == STACK_DEPTH);
        return s;
    endfunction

    task automatic append_row(input int op, input logic [ADR_W-1:0] a,
                              input logic [BUS_W-1:0] dat, input logic [BUS_W-1:0] exp,
                              input string note);
        row_op.push_back(op);
        row_adr.push_back(a);
        row_dat.push_back(dat);
        row_exp.push_back(exp);
        row_note.push_back(note);
    endtask

    // Status and PC reads against the model as it stands now
    task automatic expect_state(input string note);
        append_row(OP_STATUS, ADR_CMD, '0, model_status(), note);
        append_row(OP_PC, ADR_ELSE, '0, BUS_W'(m_pc), note);
    endtask

    task automatic load_targets(input pc_t else_target, input pc_t ipdom_target,
                                input string note);
        append_row(OP_WRITE, ADR_ELSE, BUS_W'(else_target), '0, note);
        append_row(OP_WRITE, ADR_IPDOM, BUS_W'(ipdom_target), '0, note);
        m_else  = else_target;
        m_ipdom = ipdom_target;
    endtask

    task automatic split_cmd(input tmask_t pred, input string note);
        tmask_t taken;
        tmask_t not_taken;
        taken     = m_mask & pred;
        not_taken = m_mask & ~pred;
        append_row(OP_WRITE, ADR_CMD, BUS_W'(pred), '0, note);
        if (taken != '0 && not_taken != '0) begin
            if (stk_used.size() == STACK_DEPTH) begin
                m_err = 1'b1;
            end else begin
                stk_emask.push_back(not_taken);
                stk_epc.push_back(m_else);
                stk_rmask.push_back(m_mask);
                stk_rpc.push_back(m_ipdom);
                stk_used.push_back(1'b0);
                m_mask = taken;
            end
        end
        expect_state(note);
    endtask

    task automatic join_cmd(input string note);
        logic [BUS_W-1:0] word;
        int               top;
        word               = '0;
        word[CMD_JOIN_BIT] = 1'b1;
        top                = stk_used.size() - 1;
        append_row(OP_WRITE, ADR_CMD, word, '0, note);
        if (top < 0) begin
            m_err = 1'b1;
        end else if (!stk_used[top]) begin
            // First join runs the not-taken threads at the else PC
            m_mask        = stk_emask[top];
            m_pc          = stk_epc[top];
            stk_used[top] = 1'b1;
        end else begin
            m_mask = stk_rmask[top];
            m_pc   = stk_rpc[top];
            stk_emask.delete(top);
            stk_epc.delete(top);
            stk_rmask.delete(top);
            stk_rpc.delete(top);
            stk_used.delete(top);
        end
        expect_state(note);
    endtask

    // Called on a falling edge; returns on the falling edge after the ack cycle
    task automatic bus_cycle(input logic wr, input logic [ADR_W-1:0] a,
                             input logic [BUS_W-1:0] wd, output logic [BUS_W-1:0] rd,
                             output logic acked);
        int waited;
        cyc    = 1'b1;
        stb    = 1'b1;
        we     = wr;
        adr    = a;
        dat_w  = wd;
        waited = 0;
        acked  = 1'b0;
        while (!acked && waited < ACK_WAIT) begin
            @(negedge clk);
            waited = waited + 1;
            acked  = ack;
        end
        rd = dat_r;
        if (acked) begin
            @(negedge clk);
        end
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic check_status(input int row, input tmask_t exp_mask, input logic exp_full,
                                input logic exp_empty, input logic exp_err,
                                input logic [BUS_W-1:0] got, input string note);
        tmask_t got_mask;
        got_mask = got[NUM_THREADS-1:0];
        tests    = tests + 1;
        if (got_mask !== exp_mask || got[STATUS_FULL] !== exp_full
                || got[STATUS_EMPTY] !== exp_empty || got[STATUS_ERR] !== exp_err) begin
            failures = failures + 1;
            $display("FAILED at %0t: row %0d (%s) mask %b full %b empty %b err %b,",
                     $time, row, note, got_mask, got[STATUS_FULL], got[STATUS_EMPTY],
                     got[STATUS_ERR]);
            $display("    expected mask %b full %b empty %b err %b",
                     exp_mask, exp_full, exp_empty, exp_err);
        end else begin
            $display("ok row %0d (%s): mask %b full %b empty %b err %b",
                     row, note, got_mask, exp_full, exp_empty, exp_err);
        end
    endtask

    task automatic check_pc(input int row, input pc_t exp_pc, input pc_t got,
                            input string note);
        tests = tests + 1;
        if (got !== exp_pc) begin
            failures = failures + 1;
            $display("FAILED at %0t: row %0d (%s) pc %h, expected %h",
                     $time, row, note, got, exp_pc);
        end else begin
            $display("ok row %0d (%s): pc %h", row, note, got);
        end
    endtask

    initial begin
        logic [BUS_W-1:0] rd;
        logic             acked;
        logic [31:0]      r;
        reset   = 1'b1;
        cyc     = 1'b0;
        stb     = 1'b0;
        we      = 1'b0;
        adr     = '0;
        dat_w   = '0;
        sel     = 4'hf;
        m_mask  = '1;
        m_pc    = RESET_PC;
        m_else  = '0;
        m_ipdom = '0;
        m_err   = 1'b0;

        expect_state("after reset");

        load_targets(32'h0000_2000, 32'h0000_3000, "targets");
        append_row(OP_PC, ADR_IPDOM, '0, 32'h0000_3000, "ipdom readback");
        split_cmd(4'b0101, "divergent split");
        join_cmd("else join");
        join_cmd("reconverge join");

        split_cmd(4'b1111, "uniform split all");
        split_cmd(4'b0000, "uniform split none");

        // Each level needs a strictly smaller mask, so four threads nest three deep
        load_targets(32'h0000_4000, 32'h0000_4800, "outer targets");
        split_cmd(4'b0111, "outer split");
        load_targets(32'h0000_5000, 32'h0000_5800, "middle targets");
        split_cmd(4'b0011, "middle split");
        load_targets(32'h0000_6000, 32'h0000_6800, "inner targets");
        split_cmd(4'b0001, "inner split");
        repeat (6) join_cmd("nested join");

        join_cmd("join on empty stack");

        repeat (24) begin
            r = $random(seed);
            if (r[0]) begin
                load_targets(pc_t'($random(seed)), pc_t'($random(seed)), "random targets");
                split_cmd(r[11:8], "random split");
            end else begin
                join_cmd("random join");
            end
        end

        cycle_limit = row_op.size() * 6 + 10 + 50;

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < row_op.size(); i++) begin
            bus_cycle(row_op[i] == OP_WRITE, row_adr[i], row_dat[i], rd, acked);
            if (!acked) begin
                tests    = tests + 1;
                failures = failures + 1;
                $display("Row %0d (%s): the DUT never acknowledged the bus cycle",
                         i, row_note[i]);
            end else if (row_op[i] == OP_STATUS) begin
                check_status(i, row_exp[i][NUM_THREADS-1:0], row_exp[i][STATUS_FULL],
                             row_exp[i][STATUS_EMPTY], row_exp[i][STATUS_ERR], rd,
                             row_note[i]);
            end else if (row_op[i] == OP_PC) begin
                check_pc(i, pc_t'(row_exp[i]), pc_t'(rd), row_note[i]);
            end
        end

        $display("%0d tests, %0d passed, %0d failed", tests, tests - failures, failures);
        if (failures == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- sim.f
src/simt_pkg.sv
src/dp_ram.sv
src/ipdom_stack.sv
src/divergence_ctl.sv
src/wb_simt_regs.sv
src/simt_top.sv
bench/clk_gen.sv
bench/tb_simt.sv

//--- Makefile
# Verilator build and run of the SIMT divergence unit testbench

all: obj_dir/Vtb_simt
	@out="$$(./obj_dir/Vtb_simt)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

obj_dir/Vtb_simt: sim.f $(wildcard src/*.sv bench/*.sv)
	verilator --binary --timing --assert --top-module tb_simt -f sim.f

lint:
	verilator --lint-only --timing --top-module tb_simt -f sim.f

clean:
	rm -rf obj_dir

.PHONY: all lint clean
